// File: filelist.f
hw/riscv_pkg.sv
hw/riscv_agu.sv
hw/riscv_lsu.sv
hw/riscv_dmem.sv
hw/riscv_lsu_top.sv
tb/tb_riscv_lsu_top.sv

// File: hw/riscv_agu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_agu (
  input  wire logic                          issue,
  input  wire riscv_pkg::instr_u             instr,
  input  wire logic [riscv_pkg::xlen-1:0]    rs1_val,
  input  wire logic [riscv_pkg::xlen-1:0]    rs2_val,
  output riscv_pkg::mem_req_t                req
);

  import riscv_pkg::*;

  logic            is_load;
  logic            is_store;
  logic [11:0]     imm12;
  logic [xlen-1:0] imm_sext;
  lsu_opt_t        opt;

  // opcode sits at the same place in both views
  assign is_load  = (instr.i_fmt.opcode == opcode_load);
  assign is_store = (instr.s_fmt.opcode == opcode_store);

  always_comb begin
    if (is_store) begin
      imm12 = {instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};   // split immediate
    end else begin
      imm12 = instr.i_fmt.imm;
    end
  end

  assign imm_sext = {{(xlen-12){imm12[11]}}, imm12};

  always_comb begin
    opt = lsu_opt_none;
    if (issue) begin
      if (is_load) begin
        opt = lsu_opt_load;
      end else if (is_store) begin
        opt = lsu_opt_store;
      end
    end
  end

  assign req.opt    = opt;
  assign req.funct3 = instr.i_fmt.funct3;   // same bits in both views
  assign req.addr   = rs1_val + imm_sext;   // effective address
  assign req.wdata  = rs2_val;

endmodule

`default_nettype wire

// File: hw/riscv_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dmem (
  input  wire logic                          clk,
  input  wire riscv_pkg::dmem_cmd_t          cmd,
  output logic [riscv_pkg::xlen-1:0]         rdata
);

  import riscv_pkg::*;

  logic [xlen-1:0] mem [dmem_words];

  // read old word first, write takes effect after the edge
  always_ff @(posedge clk) begin
    if (cmd.en) begin
      rdata <= mem[cmd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.en && cmd.we) begin
      for (int i = 0; i < 4; i++) begin
        if (cmd.be[i]) begin
          mem[cmd.addr][8*i +: 8] <= cmd.wdata[8*i +: 8];   // lane i
        end
      end
    end
  end

  a_addr_known: assert property (@(posedge clk)
    cmd.en |-> !$isunknown(cmd.addr));

endmodule

`default_nettype wire

// File: hw/riscv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_lsu (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire riscv_pkg::mem_req_t           req,
  input  wire logic [riscv_pkg::xlen-1:0]    rdata,
  output riscv_pkg::dmem_cmd_t               cmd,
  output logic [riscv_pkg::xlen-1:0]         lsu_result,
  output logic                               load_valid,
  output logic                               misalign
);

  import riscv_pkg::*;

  logic [1:0]      ofs;
  logic [3:0]      be_base;
  logic            size_ok;
  logic            is_access;
  logic            is_misaligned;
  logic [xlen-1:0] wdata_lanes;
  logic [2:0]      f3_q;
  logic [1:0]      ofs_q;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;

  assign ofs = req.addr[1:0];

  // size from funct3[1:0], sign bit ignored here
  always_comb begin
    size_ok       = 1'b1;
    is_misaligned = 1'b0;
    case (req.funct3[1:0])
      2'b00: begin
        be_base     = 4'b0001;
        wdata_lanes = {4{req.wdata[7:0]}};
      end
      2'b01: begin
        be_base       = 4'b0011;
        wdata_lanes   = {2{req.wdata[15:0]}};
        is_misaligned = ofs[0];
      end
      2'b10: begin
        be_base       = 4'b1111;
        wdata_lanes   = req.wdata;
        is_misaligned = (ofs != 2'b00);
      end
      default: begin
        be_base     = 4'b0000;
        wdata_lanes = req.wdata;
        size_ok     = 1'b0;   // reserved size, dropped
      end
    endcase
  end

  assign is_access = (req.opt != lsu_opt_none) && size_ok;

  assign cmd.en    = is_access && !is_misaligned;
  assign cmd.we    = is_access && !is_misaligned && (req.opt == lsu_opt_store);
  assign cmd.be    = be_base << ofs;
  assign cmd.addr  = req.addr[dmem_aw+1:2];
  assign cmd.wdata = wdata_lanes;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_valid <= 1'b0;
      misalign   <= 1'b0;
    end else begin
      load_valid <= cmd.en && !cmd.we;   // rdata arrives next cycle
      misalign   <= is_access && is_misaligned;
    end
  end

  always_ff @(posedge clk) begin
    f3_q  <= req.funct3;
    ofs_q <= ofs;
  end

  always_comb begin
    case (ofs_q)
      2'b00:   ld_byte = rdata[7:0];
      2'b01:   ld_byte = rdata[15:8];
      2'b10:   ld_byte = rdata[23:16];
      default: ld_byte = rdata[31:24];
    endcase
    ld_half = ofs_q[1] ? rdata[31:16] : rdata[15:0];
  end

  always_comb begin
    case (f3_q)
      f3_b:    lsu_result = {{(xlen-8){ld_byte[7]}}, ld_byte};
      f3_h:    lsu_result = {{(xlen-16){ld_half[15]}}, ld_half};
      f3_bu:   lsu_result = {{(xlen-8){1'b0}}, ld_byte};
      f3_hu:   lsu_result = {{(xlen-16){1'b0}}, ld_half};
      default: lsu_result = rdata;   // lw
    endcase
  end

  // issue and instr fully driven
  a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(req.opt));

  // loaded word was written earlier
  a_rdata_known: assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> !$isunknown(rdata));

endmodule

`default_nettype wire

// File: hw/riscv_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_lsu_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          issue,
  input  wire riscv_pkg::instr_u             instr,
  input  wire logic [riscv_pkg::xlen-1:0]    rs1_val,
  input  wire logic [riscv_pkg::xlen-1:0]    rs2_val,
  output logic [riscv_pkg::xlen-1:0]         lsu_result,
  output logic                               load_valid,
  output logic                               misalign
);

  import riscv_pkg::*;

  mem_req_t        req;
  dmem_cmd_t       cmd;
  logic [xlen-1:0] rdata;

  riscv_agu u_agu (
    .issue   (issue),
    .instr   (instr),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .req     (req)
  );

  riscv_lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .rdata      (rdata),
    .cmd        (cmd),
    .lsu_result (lsu_result),
    .load_valid (load_valid),
    .misalign   (misalign)
  );

  riscv_dmem u_dmem (
    .clk   (clk),
    .cmd   (cmd),
    .rdata (rdata)
  );

endmodule

`default_nettype wire

// File: hw/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  localparam int xlen = 32;

  // data memory geometry
  localparam int dmem_words = 256;
  localparam int dmem_aw    = 8;

  localparam logic [6:0] opcode_load  = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // access size and signedness
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  typedef enum logic [1:0] {
    lsu_opt_none  = 2'b00,
    lsu_opt_load  = 2'b01,
    lsu_opt_store = 2'b10
  } lsu_opt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // loads read the i view, stores the s view
  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } instr_u;

  typedef struct packed {
    lsu_opt_t          opt;
    logic [2:0]        funct3;
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic                en;
    logic                we;
    logic [3:0]          be;
    logic [dmem_aw-1:0]  addr;   // word address
    logic [xlen-1:0]     wdata;
  } dmem_cmd_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
  --top-module tb_riscv_lsu_top \
  -f filelist.f \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"

[ -f sim.log ] && cat sim.log

grep -qx "Done: no errors" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

exit 0

// File: tb/tb_riscv_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_lsu_top;

  import riscv_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        issue;
  instr_u      instr;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] lsu_result;
  logic        load_valid;
  logic        misalign;

  logic        exp_ld;      // driven with the request
  logic        exp_mis;
  logic [31:0] exp_data;
  logic        exp_ld_q;    // lined up with the response cycle
  logic        exp_mis_q;
  logic [31:0] exp_data_q;

  logic [7:0]  mem_model [1024];   // byte image of the data memory
  logic [31:0] lfsr_state;
  string       cur_test;
  int          issued_cnt;
  int          seen_cnt = 0;
  int          err_data = 0;
  int          err_timing = 0;
  int          err_timeout = 0;

  riscv_lsu_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .instr      (instr),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .lsu_result (lsu_result),
    .load_valid (load_valid),
    .misalign   (misalign)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    exp_ld_q   <= exp_ld;
    exp_mis_q  <= exp_mis;
    exp_data_q <= exp_data;
    if (rst_n && (load_valid || misalign)) begin
      seen_cnt <= seen_cnt + 1;
    end
  end

  a_load_timing: assert property (@(posedge clk) disable iff (!rst_n)
    load_valid == exp_ld_q)
    else begin
      err_timing++;
      $display("ERROR %s load_valid expected %0b actual %0b", cur_test,
               $sampled(exp_ld_q), $sampled(load_valid));
    end

  a_misalign_timing: assert property (@(posedge clk) disable iff (!rst_n)
    misalign == exp_mis_q)
    else begin
      err_timing++;
      $display("ERROR %s misalign expected %0b actual %0b", cur_test,
               $sampled(exp_mis_q), $sampled(misalign));
    end

  a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> (lsu_result == exp_data_q))
    else begin
      err_data++;
      $display("ERROR %s lsu_result expected %h actual %h", cur_test,
               $sampled(exp_data_q), $sampled(lsu_result));
    end

  function automatic logic [31:0] lfsr_shift(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_shift(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic access_misaligned(input logic [2:0] f3, input logic [31:0] ea);
    return ((f3 == f3_h || f3 == f3_hu) && ea[0]) || (f3 == f3_w && ea[1:0] != 2'b00);
  endfunction

  function automatic void apply_store(input logic [2:0] f3, input logic [31:0] ea,
                                      input logic [31:0] data);
    int n;
    n = (f3 == f3_b) ? 1 : (f3 == f3_h) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      mem_model[ea[9:0] + 10'(i)] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] expected_load(input logic [2:0] f3, input logic [31:0] ea);
    logic [7:0]  b;
    logic [15:0] h;
    b = mem_model[ea[9:0]];
    h = {mem_model[ea[9:0] + 10'd1], b};
    case (f3)
      f3_b:    return {{24{b[7]}}, b};
      f3_bu:   return {24'h0, b};
      f3_h:    return {{16{h[15]}}, h};
      f3_hu:   return {16'h0, h};
      default: return {mem_model[ea[9:0] + 10'd3], mem_model[ea[9:0] + 10'd2], h};
    endcase
  endfunction

  task automatic drive_request(input instr_u w, input logic [31:0] r1, input logic [31:0] r2,
                               input logic e_ld, input logic e_mis, input logic [31:0] e_data);
    @(posedge clk);
    issue    <= 1'b1;
    instr    <= w;
    rs1_val  <= r1;
    rs2_val  <= r2;
    exp_ld   <= e_ld;
    exp_mis  <= e_mis;
    exp_data <= e_data;
    if (e_ld || e_mis) begin
      issued_cnt++;
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    issue   <= 1'b0;
    exp_ld  <= 1'b0;
    exp_mis <= 1'b0;
  endtask

  // rs1 is chosen so that rs1 + imm lands on ea
  task automatic store_access(input logic [2:0] f3, input logic [31:0] ea,
                              input logic [31:0] data);
    instr_u      w;
    logic [11:0] imm;
    logic        mis;
    imm = 12'(rand_bits(12));
    w = '0;
    w.s_fmt.imm_hi = imm[11:5];
    w.s_fmt.imm_lo = imm[4:0];
    w.s_fmt.rs2    = 5'(rand_bits(5));
    w.s_fmt.rs1    = 5'(rand_bits(5));
    w.s_fmt.funct3 = f3;
    w.s_fmt.opcode = opcode_store;
    mis = access_misaligned(f3, ea);
    if (!mis) begin
      apply_store(f3, ea, data);
    end
    drive_request(w, ea - sext12(imm), data, 1'b0, mis, 32'h0);
  endtask

  task automatic load_access(input logic [2:0] f3, input logic [31:0] ea);
    instr_u      w;
    logic [11:0] imm;
    logic        mis;
    imm = 12'(rand_bits(12));
    w = '0;
    w.i_fmt.imm    = imm;
    w.i_fmt.rs1    = 5'(rand_bits(5));
    w.i_fmt.rd     = 5'(rand_bits(5));
    w.i_fmt.funct3 = f3;
    w.i_fmt.opcode = opcode_load;
    mis = access_misaligned(f3, ea);
    drive_request(w, ea - sext12(imm), rand_bits(32), !mis, mis,
                  mis ? 32'h0 : expected_load(f3, ea));
  endtask

  // store-shaped word with an opcode that is neither load nor store
  task automatic foreign_opcode(input logic [6:0] op, input logic [31:0] ea);
    instr_u      w;
    logic [11:0] imm;
    imm = 12'(rand_bits(12));
    w = '0;
    w.s_fmt.imm_hi = imm[11:5];
    w.s_fmt.imm_lo = imm[4:0];
    w.s_fmt.funct3 = f3_w;
    w.s_fmt.opcode = op;
    drive_request(w, ea - sext12(imm), rand_bits(32), 1'b0, 1'b0, 32'h0);
  endtask

  task automatic wait_drain();
    int cycles;
    idle_cycle();
    cycles = 0;
    while (seen_cnt != issued_cnt && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (seen_cnt != issued_cnt) begin
      err_timeout++;
      $display("timeout in %s: responses still missing after 20 cycles", cur_test);
      issued_cnt = seen_cnt;
    end
  endtask

  initial begin
    logic [31:0] base;
    logic [31:0] bases [4];
    clk        = 1'b0;
    rst_n      = 1'b0;
    issue      = 1'b0;
    instr      = '0;
    rs1_val    = '0;
    rs2_val    = '0;
    exp_ld     = 1'b0;
    exp_mis    = 1'b0;
    exp_data   = '0;
    issued_cnt = 0;
    cur_test   = "reset";
    lfsr_state = 32'h9b88_27a8;
    foreach (mem_model[i]) begin
      mem_model[i] = 8'h00;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycle();

    cur_test = "sw_lw";
    for (int k = 0; k < 8; k++) begin
      base = rand_bits(32) & ~32'h3;
      store_access(f3_w, base, rand_bits(32));
      idle_cycle();
      load_access(f3_w, base);
      wait_drain();
    end

    cur_test = "sub_word_store";
    for (int k = 0; k < 16; k++) begin
      base = rand_bits(32) & ~32'h3;
      store_access(f3_w, base, rand_bits(32));
      store_access(f3_b, base | rand_bits(2), rand_bits(32));
      store_access(f3_h, base | (rand_bits(1) << 1), rand_bits(32));
      load_access(f3_w, base);
      wait_drain();
    end

    cur_test = "load_extend";
    for (int k = 0; k < 4; k++) begin
      base = rand_bits(32) & ~32'h3;
      store_access(f3_w, base, (k == 0) ? 32'h80ff_7f01 : rand_bits(32));
      for (int o = 0; o < 4; o++) begin
        load_access(f3_b, base + o);
        load_access(f3_bu, base + o);
      end
      for (int o = 0; o < 4; o += 2) begin
        load_access(f3_h, base + o);
        load_access(f3_hu, base + o);
      end
      wait_drain();
    end

    cur_test = "misaligned";
    base = rand_bits(32) & ~32'h3;
    store_access(f3_w, base, rand_bits(32));
    load_access(f3_h, base + 1);
    load_access(f3_hu, base + 3);
    for (int o = 1; o < 4; o++) begin
      load_access(f3_w, base + o);
      store_access(f3_w, base + o, rand_bits(32));
    end
    store_access(f3_h, base + 1, rand_bits(32));
    store_access(f3_h, base + 3, rand_bits(32));
    load_access(f3_w, base);   // memory must be unchanged
    wait_drain();

    cur_test = "other_opcode";
    base = rand_bits(32) & ~32'h3;
    store_access(f3_w, base, rand_bits(32));
    foreign_opcode(7'b0110011, base);
    foreign_opcode(7'b0010011, base);
    foreign_opcode(7'b0100111, base);
    foreign_opcode(7'b0000111, base);
    load_access(f3_w, base);
    wait_drain();

    cur_test = "back_to_back";
    for (int k = 0; k < 4; k++) begin
      bases[k] = rand_bits(32) & ~32'h3;
      store_access(f3_w, bases[k], rand_bits(32));
      load_access(f3_w, bases[k]);   // sees the store one cycle earlier
    end
    store_access(f3_b, bases[0] + 2, rand_bits(32));
    load_access(f3_bu, bases[0] + 2);
    for (int k = 0; k < 4; k++) begin
      load_access(f3_w, bases[k]);
    end
    wait_drain();

    $display("summary: data errors %0d, timing errors %0d, timeouts %0d",
             err_data, err_timing, err_timeout);
    if (err_data + err_timing + err_timeout == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
